// ==== div_unit.f ====
hdl/div_pkg.sv
hdl/div_special.sv
hdl/div_lane.sv
hdl/div_dispatch.sv
hdl/div_collect.sv
hdl/div_unit.sv
sim/div_unit_properties.sv
sim/div_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for div_unit

TOOL  := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := div_unit_tb
FLIST := div_unit.f

BUILD := obj_dir
LOG   := sim.log
SRCS  := $(shell grep -v '^+' $(FLIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FLIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG)

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== sim/div_unit_tb.sv ====
// ========================================
// div_unit_tb: random and corner-case
// divide traffic with a tagged scoreboard
// ========================================
`timescale 1ns/1ns
`default_nettype none

module div_unit_tb;

  import div_pkg::*;

  localparam int TIMEOUT = 400;          // cycles allowed per wait
  localparam int N_TAGS  = 1 << TAG_W;
  localparam int N_RAND  = 120;

  logic             clk;
  logic             rst_n;
  logic             req_valid_i;
  logic             req_ready_o;
  logic             rsp_ready_i;
  logic             rsp_valid_o;
  div_req_t         req_i;
  div_rsp_t         rsp_o;

  integer           seed = 32'h28742d32;
  int               errors = 0;
  int               checks = 0;
  int               issued [N_TAGS];     // per tag, written by stimulus
  int               returned [N_TAGS];   // per tag, written by compare
  logic [XLEN-1:0]  exp_data [N_TAGS];
  logic [TAG_W-1:0] next_tag = '0;
  logic             bp_mode = 1'b0;      // random rsp_ready_i when set

  div_unit dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ========================================
  // reference model and helpers
  function automatic logic [XLEN-1:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic logic [XLEN-1:0] ref_div(input div_op_e op,
                                              input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic signed [31:0]     sa32;
    logic signed [31:0]     sb32;
    logic [XLEN-1:0]        q64s, r64s, q64u, r64u;
    logic [31:0]            q32s, r32s, q32u, r32u;
    logic                   zero64, zero32, ovf64, ovf32;
    sa     = a;
    sb     = b;
    sa32   = a[31:0];
    sb32   = b[31:0];
    zero64 = (b == '0);
    zero32 = (b[31:0] == '0);
    ovf64  = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
    ovf32  = (a[31:0] == 32'h8000_0000) && (b[31:0] == '1);
    {q64s, r64s, q64u, r64u} = '0;
    {q32s, r32s, q32u, r32u} = '0;
    // only divide where the operators are defined
    if (!zero64 && !ovf64) begin
      q64s = sa / sb;
      r64s = sa % sb;   // sign follows dividend
    end
    if (!zero64) begin
      q64u = a / b;
      r64u = a % b;
    end
    if (!zero32 && !ovf32) begin
      q32s = sa32 / sb32;
      r32s = sa32 % sb32;
    end
    if (!zero32) begin
      q32u = a[31:0] / b[31:0];
      r32u = a[31:0] % b[31:0];
    end
    case (op)
      OP_DIV:   return zero64 ? '1 : (ovf64 ? a : q64s);
      OP_DIVU:  return zero64 ? '1 : q64u;
      OP_REM:   return zero64 ? a : (ovf64 ? '0 : r64s);
      OP_REMU:  return zero64 ? a : r64u;
      OP_DIVW:  return zero32 ? '1 : (ovf32 ? sext32(a[31:0]) : sext32(q32s));
      OP_DIVUW: return zero32 ? '1 : sext32(q32u);
      OP_REMW:  return zero32 ? sext32(a[31:0]) : (ovf32 ? '0 : sext32(r32s));
      OP_REMUW: return zero32 ? sext32(a[31:0]) : sext32(r32u);
      default:  return '0;
    endcase
  endfunction

  function automatic div_op_e op_from_index(input int idx);
    case (idx)
      0:       return OP_DIV;
      1:       return OP_DIVU;
      2:       return OP_REM;
      3:       return OP_REMU;
      4:       return OP_DIVW;
      5:       return OP_DIVUW;
      6:       return OP_REMW;
      default: return OP_REMUW;
    endcase
  endfunction

  function automatic int outstanding();
    int sum;
    sum = 0;
    for (int t = 0; t < N_TAGS; t++) sum += issued[t] - returned[t];
    return sum;
  endfunction

  task automatic check_val(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                           input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic abort_run(input string what);
    $display("run stopped at %0t: %s", $time, what);
    $display("errors=%0d checks=%0d", errors + 1, checks);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  // ========================================
  // stimulus
  // drives valid high on the next edge, caller lowers it
  task automatic send(input div_op_e op, input logic [XLEN-1:0] a,
                      input logic [XLEN-1:0] b);
    div_req_t r;
    int       cnt;
    cnt = 0;
    while (issued[next_tag] != returned[next_tag]) begin  // tag still in flight
      if (cnt == TIMEOUT) abort_run("a tag never came back from the unit");
      cnt++;
      @(negedge clk);
    end
    r.op       = op;
    r.tag      = next_tag;
    r.dividend = a;
    r.divisor  = b;
    exp_data[next_tag] = ref_div(op, a, b);
    issued[next_tag]++;
    next_tag++;
    @(posedge clk);
    req_valid_i <= 1'b1;
    req_i       <= r;
  endtask

  task automatic issue(input div_op_e op, input logic [XLEN-1:0] a,
                       input logic [XLEN-1:0] b);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!req_ready_o) begin
      if (cnt == TIMEOUT) abort_run("req_ready_o stayed low, no lane came free");
      cnt++;
      @(negedge clk);
    end
    send(op, a, b);
    @(posedge clk);
    req_valid_i <= 1'b0;
  endtask

  task automatic issue_random();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    div_op_e         op;
    op = op_from_index($unsigned($random(seed)) % 8);
    a  = {$random(seed), $random(seed)};
    b  = {$random(seed), $random(seed)} >> ($unsigned($random(seed)) % 64);
    if (b[31:0] == '0) b[0] = 1'b1;   // nonzero for both widths
    issue(op, a, b);
  endtask

  task automatic wait_drained();
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (outstanding() != 0) begin
      if (cnt == TIMEOUT) abort_run("responses still missing after the drain wait");
      cnt++;
      @(negedge clk);
    end
  endtask

  // every lane busy, then the unit must refuse
  task automatic fill_lanes();
    wait_drained();
    for (int n = 0; n < NUM_LANES; n++) begin
      send((n % 2 == 0) ? OP_DIV : OP_REMU, {$random(seed), $random(seed)},
           XLEN'(n + 3));
    end
    @(posedge clk);
    req_valid_i <= 1'b0;
    @(negedge clk);
    check_val(XLEN'(req_ready_o), '0, "req_ready_o with every lane busy");
    repeat (40) @(negedge clk);        // lanes still iterating
    check_val(XLEN'(req_ready_o), '0, "req_ready_o before any lane drained");
  endtask

  // ========================================
  // response side
  initial begin : ready_drive
    logic ready_next;
    rsp_ready_i = 1'b0;
    forever begin
      @(negedge clk);
      ready_next = bp_mode ? (($random(seed) & 1) != 0) : 1'b1;
      @(posedge clk);
      rsp_ready_i <= ready_next;
    end
  end

  initial begin : compare
    logic [TAG_W-1:0] t;
    forever begin
      @(negedge clk);
      if (!rst_n && rsp_valid_o && rsp_ready_i) begin  // taken at next edge
        t = rsp_o.tag;
        if (issued[t] == returned[t]) begin
          errors++;
          $display("%0t: response for tag %0d which has no request in flight", $time, t);
        end else begin
          check_val(rsp_o.data, exp_data[t], $sformatf("data for tag %0d", t));
          returned[t]++;
        end
      end
    end
  end

  initial begin : main
    rst_n       = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b0;
    @(negedge clk);
    check_val(XLEN'(req_ready_o), XLEN'(1), "req_ready_o after reset");
    check_val(XLEN'(rsp_valid_o), '0, "rsp_valid_o after reset");

    // zero divisors, W forms see only the low word
    issue(OP_DIV,   64'd123, 64'd0);
    issue(OP_DIVUW, 64'd123, 64'hffff_0000_0000_0000);
    issue(OP_REM,   64'hffff_ffff_ffff_fffb, 64'd0);
    issue(OP_REMW,  64'h1234_5678_9abc_def0, 64'h1_0000_0000);
    issue(OP_REMU,  64'h8000_0000_0000_0001, 64'd0);
    // signed overflow
    issue(OP_DIV,   64'h8000_0000_0000_0000, '1);
    issue(OP_REM,   64'h8000_0000_0000_0000, '1);
    issue(OP_DIVW,  64'h5555_5555_8000_0000, 64'h1234_5678_ffff_ffff);
    issue(OP_REMW,  64'h5555_5555_8000_0000, '1);
    // zero and minus-one operands
    issue(OP_DIV,   64'd0, 64'd7);
    issue(OP_REM,   64'd0, '1);
    issue(OP_DIV,   '1, '1);
    issue(OP_DIVU,  '1, '1);
    issue(OP_REMUW, '1, 64'd3);

    for (int n = 0; n < N_RAND; n++) issue_random();
    fill_lanes();
    @(posedge clk);
    bp_mode = 1'b1;
    for (int n = 0; n < N_RAND; n++) issue_random();
    wait_drained();
    repeat (8) @(negedge clk);         // a stray or repeated response shows here
    check_val(XLEN'(rsp_valid_o), '0, "rsp_valid_o with nothing in flight");

    $display("errors=%0d checks=%0d", errors, checks);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/div_unit_properties.sv ====
// ========================================
// div_unit_properties: handshake checks
// bound into div_unit
// ========================================
`timescale 1ns/1ns
`default_nettype none

module div_unit_properties (
  input logic              clk,
  input logic              rst_n,
  input logic              req_valid_i,
  input logic              req_ready_o,
  input logic              rsp_ready_i,
  input logic              rsp_valid_o,
  input div_pkg::div_rsp_t rsp_o
);

  // strobe only while a lane is idle
  a_req_legal : assert property (@(posedge clk) disable iff (rst_n)
    req_valid_i |-> req_ready_o)
    else $error("request strobe while req_ready_o is low");

  // response held until taken
  a_rsp_hold : assert property (@(posedge clk) disable iff (rst_n)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else $error("response changed or dropped before it was taken");

  a_reset_vals : assert property (@(posedge clk)
    rst_n |=> !rsp_valid_o && req_ready_o)   // one edge after a reset cycle
    else $error("wrong handshake levels after reset");

endmodule

bind div_unit div_unit_properties u_props (.*);

`default_nettype wire

// ==== hdl/div_unit.sv ====
// ========================================
// div_unit: RV64 M divide unit, parallel
// lanes between dispatcher and collector
// ========================================
`timescale 1ns/1ns
`default_nettype none

module div_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid_i,
  input  div_pkg::div_req_t  req_i,
  output logic               req_ready_o,
  input  logic               rsp_ready_i,
  output logic               rsp_valid_o,
  output div_pkg::div_rsp_t  rsp_o
);

  import div_pkg::*;

  logic [NUM_LANES-1:0] lane_start;
  logic [NUM_LANES-1:0] lane_idle;
  logic [NUM_LANES-1:0] lane_done;
  logic [NUM_LANES-1:0] lane_ack;
  div_req_t             lane_req;
  div_rsp_t             lane_rsp [NUM_LANES];

  div_dispatch u_dispatch (
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .lane_idle_i  (lane_idle),
    .req_ready_o  (req_ready_o),
    .lane_start_o (lane_start),
    .lane_req_o   (lane_req)
  );

  // ========================================
  // divider lanes
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    div_lane u_lane (
      .clk     (clk),
      .rst_n   (rst_n),
      .start_i (lane_start[i]),
      .req_i   (lane_req),
      .ack_i   (lane_ack[i]),
      .idle_o  (lane_idle[i]),
      .done_o  (lane_done[i]),
      .rsp_o   (lane_rsp[i])
    );
  end

  div_collect u_collect (
    .clk         (clk),
    .rst_n       (rst_n),
    .lane_done_i (lane_done),
    .lane_rsp_i  (lane_rsp),
    .rsp_ready_i (rsp_ready_i),
    .lane_ack_o  (lane_ack),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

endmodule

`default_nettype wire

// ==== hdl/div_collect.sv ====
// ========================================
// div_collect: round-robin drain of done
// lanes into the response register
// ========================================
`timescale 1ns/1ns
`default_nettype none

module div_collect (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [div_pkg::NUM_LANES-1:0]     lane_done_i,
  input  div_pkg::div_rsp_t                 lane_rsp_i [div_pkg::NUM_LANES],
  input  logic                              rsp_ready_i,
  output logic [div_pkg::NUM_LANES-1:0]     lane_ack_o,
  output logic                              rsp_valid_o,
  output div_pkg::div_rsp_t                 rsp_o
);

  import div_pkg::*;

  logic [LANE_W-1:0] ptr_q;      // last lane served
  logic [LANE_W-1:0] sel_idx;
  logic              sel_any;
  logic              load_en;
  logic              rsp_valid_q;
  div_rsp_t          rsp_q;

  // ========================================
  // pick next done lane after ptr_q
  always_comb begin : pick
    int j;
    sel_any = 1'b0;
    sel_idx = ptr_q;
    for (int k = 1; k <= NUM_LANES; k++) begin
      j = int'(ptr_q) + k;
      if (j >= NUM_LANES) j = j - NUM_LANES;
      if (!sel_any && lane_done_i[j]) begin
        sel_any = 1'b1;
        sel_idx = LANE_W'(j);
      end
    end
  end

  // register empty or being taken this edge
  assign load_en = sel_any & (~rsp_valid_q | rsp_ready_i);

  always_comb begin
    lane_ack_o = '0;
    if (load_en) lane_ack_o[sel_idx] = 1'b1;  // same cycle as the load
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      rsp_valid_q <= 1'b0;
      ptr_q       <= LANE_W'(NUM_LANES - 1);  // lane 0 first
    end else if (load_en) begin
      rsp_valid_q <= 1'b1;
      ptr_q       <= sel_idx;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_en) rsp_q <= lane_rsp_i[sel_idx];
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// ==== hdl/div_dispatch.sv ====
// ========================================
// div_dispatch: starts each request on the
// lowest-numbered idle lane
// ========================================
`timescale 1ns/1ns
`default_nettype none

module div_dispatch (
  input  logic                              req_valid_i,
  input  div_pkg::div_req_t                 req_i,
  input  logic [div_pkg::NUM_LANES-1:0]     lane_idle_i,
  output logic                              req_ready_o,
  output logic [div_pkg::NUM_LANES-1:0]     lane_start_o,
  output div_pkg::div_req_t                 lane_req_o
);

  import div_pkg::*;

  logic [NUM_LANES-1:0] first_idle;  // one-hot
  logic                 found;

  // priority encoder, lane 0 wins
  always_comb begin
    first_idle = '0;
    found      = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (lane_idle_i[i] && !found) begin
        first_idle[i] = 1'b1;
        found         = 1'b1;
      end
    end
  end

  // ready while any lane can take work
  assign req_ready_o = |lane_idle_i;

  // the strobe is only legal with ready high
  assign lane_start_o = first_idle & {NUM_LANES{req_valid_i}};

  // broadcast, only the started lane latches
  assign lane_req_o = req_i;

endmodule

`default_nettype wire

// ==== hdl/div_lane.sv ====
// ========================================
// div_lane: one-bit-per-cycle restoring
// divider on magnitudes, sign fix at end
// ========================================
`timescale 1ns/1ns
`default_nettype none

module div_lane (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start_i,
  input  div_pkg::div_req_t  req_i,
  input  logic               ack_i,
  output logic               idle_o,
  output logic               done_o,
  output div_pkg::div_rsp_t  rsp_o
);

  import div_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    DO_DIV,
    FINISH
  } lane_state_e;

  lane_state_e          state_q, state_d;
  div_special_t         spec;

  // latched request info
  logic [TAG_W-1:0]     tag_q;
  div_op_e              op_q;
  logic                 special_q;
  logic                 q_sign_q;
  logic                 r_sign_q;
  logic [CNT_W-1:0]     cnt_q;
  logic [2*XLEN-1:0]    rq_q;      // remainder:quotient
  logic [XLEN-1:0]      dvs_q;

  // load side
  logic                 w_op, s_op;
  logic                 a_neg, b_neg;
  logic [XLEN-1:0]      a_abs, b_abs;
  logic [XLEN-1:0]      a_init, b_init;
  logic [CNT_W-1:0]     cnt_init;

  // iteration
  logic [XLEN:0]        diff;
  logic [2*XLEN-1:0]    rq_shift;

  // result side
  logic [XLEN-1:0]      raw, signed_val;
  logic                 res_neg;

  div_special u_special (
    .op_i       (req_i.op),
    .dividend_i (req_i.dividend),
    .divisor_i  (req_i.divisor),
    .special_o  (spec)
  );

  // ========================================
  // operand preparation
  always_comb begin
    w_op     = op_is_word(req_i.op);
    s_op     = op_is_signed(req_i.op);
    a_neg    = s_op & (w_op ? req_i.dividend[31] : req_i.dividend[XLEN-1]);
    b_neg    = s_op & (w_op ? req_i.divisor[31]  : req_i.divisor[XLEN-1]);
    a_abs    = a_neg ? -req_i.dividend : req_i.dividend;  // low word also fine for W
    b_abs    = b_neg ? -req_i.divisor  : req_i.divisor;
    // W dividend sits high in the low word, 32 steps then suffice
    a_init   = w_op ? {a_abs[31:0], 32'b0} : a_abs;
    b_init   = w_op ? {32'b0, b_abs[31:0]} : b_abs;
    cnt_init = w_op ? CNT_W'(32) : CNT_W'(XLEN);
  end

  assign diff     = rq_q[2*XLEN-1:XLEN-1] - {1'b0, dvs_q};
  assign rq_shift = {rq_q[2*XLEN-2:0], 1'b0};

  // ========================================
  // controller
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_i) state_d = spec.hit ? FINISH : DO_DIV;
      DO_DIV:  if (cnt_q == CNT_W'(1)) state_d = FINISH;  // last step
      FINISH:  if (ack_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (state_q == IDLE && start_i) begin
      tag_q     <= req_i.tag;
      op_q      <= req_i.op;
      special_q <= spec.hit;
      if (spec.hit) begin
        rq_q <= {{XLEN{1'b0}}, spec.value};  // value rides in the low word
      end else begin
        rq_q     <= {{XLEN{1'b0}}, a_init};
        dvs_q    <= b_init;
        cnt_q    <= cnt_init;
        q_sign_q <= a_neg ^ b_neg;
        r_sign_q <= a_neg;                   // remainder follows dividend
      end
    end else if (state_q == DO_DIV) begin
      cnt_q <= cnt_q - CNT_W'(1);
      if (diff[XLEN]) begin
        rq_q <= rq_shift;                    // restore
      end else begin
        rq_q <= {diff[XLEN-1:0], rq_shift[XLEN-1:1], 1'b1};
      end
    end
  end

  // ========================================
  // result select and sign fix
  always_comb begin
    raw        = op_is_rem(op_q) ? rq_q[2*XLEN-1:XLEN] : rq_q[XLEN-1:0];
    res_neg    = op_is_rem(op_q) ? r_sign_q : q_sign_q;
    signed_val = res_neg ? -raw : raw;
    rsp_o.tag  = tag_q;
    if (special_q) begin
      rsp_o.data = rq_q[XLEN-1:0];
    end else if (op_is_word(op_q)) begin
      rsp_o.data = {{32{signed_val[31]}}, signed_val[31:0]};
    end else begin
      rsp_o.data = signed_val;
    end
  end

  assign idle_o = (state_q == IDLE);
  assign done_o = (state_q == FINISH);  // held until acked

endmodule

`default_nettype wire

// ==== hdl/div_special.sv ====
// ========================================
// div_special: divide-by-zero and signed
// overflow detection with their results
// ========================================
`timescale 1ns/1ns
`default_nettype none

module div_special (
  input  div_pkg::div_op_e                op_i,
  input  logic [div_pkg::XLEN-1:0]        dividend_i,
  input  logic [div_pkg::XLEN-1:0]        divisor_i,
  output div_pkg::div_special_t           special_o
);

  import div_pkg::*;

  logic            is_rem;
  logic            is_word;
  logic            is_signed;
  logic            div_zero;
  logic            div_ovf;
  logic            ovf_64;
  logic            ovf_32;
  logic [XLEN-1:0] dividend_sext32;

  assign is_rem    = op_is_rem(op_i);
  assign is_word   = op_is_word(op_i);
  assign is_signed = op_is_signed(op_i);

  assign dividend_sext32 = {{32{dividend_i[31]}}, dividend_i[31:0]};

  // ========================================
  // detection
  // W forms only look at the low word of the divisor
  assign div_zero = is_word ? ~|divisor_i[31:0] : ~|divisor_i;

  // most negative / -1
  assign ovf_64 = (dividend_i == {1'b1, {(XLEN-1){1'b0}}}) && (&divisor_i);
  assign ovf_32 = (dividend_i[31:0] == 32'h8000_0000) && (&divisor_i[31:0]);

  assign div_ovf = is_signed && !div_zero && (is_word ? ovf_32 : ovf_64);

  // ========================================
  // architectural result
  always_comb begin
    special_o.hit   = div_zero | div_ovf;
    special_o.value = '0;
    if (div_zero) begin
      if (is_rem) begin
        special_o.value = is_word ? dividend_sext32 : dividend_i;  // rem keeps dividend
      end else begin
        special_o.value = '1;                                     // quotient all ones
      end
    end else if (div_ovf) begin
      if (is_rem) begin
        special_o.value = '0;
      end else begin
        special_o.value = is_word ? dividend_sext32 : dividend_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/div_pkg.sv ====
// ========================================
// div_pkg: shared types and constants for
// the multi-lane RV64 divide unit
// ========================================
`default_nettype none

package div_pkg;

  // ========================================
  // unit sizing
  localparam int XLEN      = 64;
  localparam int TAG_W     = 4;
  localparam int NUM_LANES = 4;
  localparam int LANE_W    = $clog2(NUM_LANES);
  localparam int CNT_W     = $clog2(XLEN) + 1;   // must hold 64

  // one-hot op codes, same bit order as the decoder
  typedef enum logic [7:0] {
    OP_REM   = 8'b1000_0000,
    OP_REMU  = 8'b0100_0000,
    OP_REMUW = 8'b0010_0000,
    OP_REMW  = 8'b0001_0000,
    OP_DIV   = 8'b0000_1000,
    OP_DIVU  = 8'b0000_0100,
    OP_DIVUW = 8'b0000_0010,
    OP_DIVW  = 8'b0000_0001
  } div_op_e;

  // ========================================
  // payloads
  typedef struct packed {
    div_op_e           op;
    logic [TAG_W-1:0]  tag;
    logic [XLEN-1:0]   dividend;
    logic [XLEN-1:0]   divisor;
  } div_req_t;   // 140 bits

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [XLEN-1:0]   data;
  } div_rsp_t;   // 68 bits

  typedef struct packed {
    logic              hit;     // div by zero or overflow
    logic [XLEN-1:0]   value;
  } div_special_t;

  // op class helpers
  function automatic logic op_is_rem(div_op_e op);
    return op inside {OP_REM, OP_REMU, OP_REMUW, OP_REMW};
  endfunction

  function automatic logic op_is_word(div_op_e op);
    return op inside {OP_REMUW, OP_REMW, OP_DIVUW, OP_DIVW};
  endfunction

  function automatic logic op_is_signed(div_op_e op);
    return op inside {OP_REM, OP_REMW, OP_DIV, OP_DIVW};
  endfunction

endpackage

`default_nettype wire
